/* sccMegaRom.f */
+incdir+logic
logic/cartridgePkg.sv
logic/cartridgeIfs.sv
logic/bankMapper.sv
logic/sccSoundRegs.sv
logic/cartridgeBusCtrl.sv
logic/sccMegaRom.sv
dv/tbClock.sv
dv/sccMegaRomTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Builds the cartridge testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir &&
verilator --binary -j 0 -f sccMegaRom.f --top-module sccMegaRomTb -o sccMegaRomSim &&
./obj_dir/sccMegaRomSim || { echo "Simulation failed"; exit 1; }

/* dv/sccMegaRomPatterns.hex */
// op(0 read, 1 write, F end) addr wrData | expected: rdData romHit romAddr
// romAddr is the 19-bit ROM address, bank number above the 13-bit page offset
0 4000 00 FF 1 00000
0 6123 00 FF 1 02123
0 8456 00 FF 1 04456
0 A789 00 FF 1 06789
1 5000 05 FF 1 01000
1 7000 0A FF 1 03000
1 9000 11 FF 1 05000
1 B000 3E FF 1 07000
0 4010 00 FF 1 0A010
0 7FFF 00 FF 1 15FFF
0 9800 00 FF 1 23800
0 B123 00 FF 1 7D123
0 C000 00 FF 0 00000
1 E000 55 FF 0 00000
1 9000 3F FF 1 23000
1 9800 5A FF 0 00000
0 9800 00 5A 0 00000
1 9865 C3 FF 0 00000
0 9A00 00 5A 0 00000
1 9881 0F FF 0 00000
0 9881 00 FF 0 00000
0 98A0 00 FF 0 00000
1 BFFE 20 FF 0 00000
0 9800 00 FF 1 7F800
1 B000 80 FF 1 7D000
1 B800 11 FF 0 00000
0 B800 00 11 0 00000
0 B885 00 C3 0 00000
0 B8A0 00 FF 0 00000
1 BFFF 10 FF 0 00000
1 5000 22 FF 1 0B000
0 4000 00 FF 1 0A000
1 BFFE 01 FF 0 00000
1 5000 02 FF 1 0B000
1 7000 33 FF 1 15000
0 4000 00 FF 1 04000
0 6000 00 FF 1 14000
F 0000 00 00 0 00000

/* dv/sccMegaRomTb.sv */
// Replays dv/sccMegaRomPatterns.hex against the cartridge over the req/ack handshake
// The simulation must run from the project root so the pattern path resolves
// Every pattern line is op, address, write data, rdData, romHit and romAddr
// An op field of F ends the list
`timescale 1ns/1ps
`include "cartridge_settings.svh"

module sccMegaRomTb;

    localparam int FieldsPerLine = 6;
    localparam int MaxPatterns   = 64;
    localparam int RomAddrBits   = `ROM_BANK_BITS + 13;

    logic                   CLK;
    logic                   RESET_n;
    logic                   req;
    cartridgePkg::busOp_t   op;
    logic [15:0]            addr;
    logic [7:0]             wrData;
    logic                   ack;
    logic [7:0]             rdData;
    logic                   romHit;
    logic [RomAddrBits-1:0] romAddr;

    // One word per field and six words per access
    logic [19:0] patWords [FieldsPerLine * MaxPatterns];
    int          patCount;
    int          cycleCount = 0;
    int          cycleLimit = 100;
    logic [31:0] lfsrState;

    tbClock #(.PeriodNs(8), .ResetCycles(4)) i_tbClock (
        .CLK     (CLK),
        .RESET_n (RESET_n)
    );

    sccMegaRom i_sccMegaRom (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .i_req     (req),
        .i_op      (op),
        .i_addr    (addr),
        .i_wrData  (wrData),
        .o_ack     (ack),
        .o_rdData  (rdData),
        .o_romHit  (romHit),
        .o_romAddr (romAddr)
    );

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] stepLfsr(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h80200003;
        end
        return next;
    endfunction

    // One LFSR step per bit taken
    task automatic drawBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsrState = stepLfsr(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Runs one full four-phase access, entered and left just after a falling edge
    task automatic runAccess(input int idx);
        logic [3:0]             opField;
        logic [15:0]            addrField;
        logic [7:0]             wrField;
        logic [7:0]             expRdData;
        logic                   expRomHit;
        logic [RomAddrBits-1:0] expRomAddr;
        int                     base;
        int                     edges;
        int                     holdCycles;
        int                     idleCycles;
        string                  tag;

        base       = idx * FieldsPerLine;
        opField    = patWords[base][3:0];
        addrField  = patWords[base + 1][15:0];
        wrField    = patWords[base + 2][7:0];
        expRdData  = patWords[base + 3][7:0];
        expRomHit  = patWords[base + 4][0];
        expRomAddr = patWords[base + 5][RomAddrBits-1:0];
        tag        = $sformatf("access %0d to %h", idx, addrField);

        // No new request before the previous ack has gone low
        checkValue(32'(ack), 32'd0, {tag, " ack low before req"});
        req    = 1'b1;
        op     = cartridgePkg::busOp_t'(opField[0]);
        addr   = addrField;
        wrData = wrField;

        // Count the rising edges from the first one that sees req until ack
        edges = 0;
        do begin
            @(negedge CLK);
            edges++;
        end while (!ack);
        checkValue(32'(edges), 32'(`ACK_LATENCY), {tag, " ack latency"});
        checkValue(32'(rdData), 32'(expRdData), {tag, " rdData"});
        checkValue(32'(romHit), 32'(expRomHit), {tag, " romHit"});
        checkValue(32'(romAddr), 32'(expRomAddr), {tag, " romAddr"});

        // Under back-pressure the result has to stay put while req is held
        drawBits(2, holdCycles);
        for (int i = 0; i < holdCycles; i++) begin
            @(negedge CLK);
            checkValue(32'({ack, romHit, rdData, romAddr}),
                       32'({1'b1, expRomHit, expRdData, expRomAddr}),
                       {tag, " result held under req"});
        end

        req = 1'b0;
        @(negedge CLK);
        checkValue(32'(ack), 32'd0, {tag, " ack falls after req drops"});

        drawBits(2, idleCycles);
        repeat (idleCycles) @(negedge CLK);
    endtask

    // Hang guard sized from the pattern count
    always @(posedge CLK) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles before all accesses finished", cycleCount);
            $display("RESULT: FAIL");
            $fatal(1, "Simulation timeout");
        end
    end

    initial begin
        req       = 1'b0;
        op        = cartridgePkg::OP_READ;
        addr      = 16'h0000;
        wrData    = 8'h00;
        lfsrState = 32'hb222;

        $readmemh("dv/sccMegaRomPatterns.hex", patWords);
        patCount = 0;
        while (patCount < MaxPatterns && patWords[patCount * FieldsPerLine][3:0] != 4'hF) begin
            patCount++;
        end
        cycleLimit = patCount * (`ACK_LATENCY + 8) + 100;

        @(posedge RESET_n);
        @(negedge CLK);
        // Idle outputs after reset are ack low, no hit, FFh data and a zero ROM address
        checkValue(32'({ack, romHit, rdData, romAddr}),
                   32'({1'b0, 1'b0, 8'hFF, {RomAddrBits{1'b0}}}), "outputs after reset");

        for (int i = 0; i < patCount; i++) begin
            runAccess(i);
        end

        if (patCount == 0) begin
            $display("No access patterns were found in the pattern file");
            $display("RESULT: FAIL");
            $fatal(1, "Empty pattern list");
        end else begin
            $display("Finished %0d accesses", patCount);
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* dv/tbClock.sv */
// Free-running testbench clock and active-low reset
// Reset is released on a falling edge so it never races the sampling edge
`timescale 1ns/1ps

module tbClock #(
    parameter int PeriodNs    = 8,
    parameter int ResetCycles = 4
) (
    output logic CLK,
    output logic RESET_n
);

    initial begin
        CLK     = 1'b0;
        RESET_n = 1'b0;
        // Hold reset over the requested number of rising edges
        repeat (ResetCycles) @(posedge CLK);
        @(negedge CLK);
        RESET_n = 1'b1;
    end

    always #(PeriodNs / 2) CLK = ~CLK;

endmodule

/* logic/sccMegaRom.sv */
// MegaROM cartridge with SCC and SCC-I sound register front end
// The ROM is external and addressed through o_romAddr when o_romHit is set
// Audio generation, interrupts and wait states are not part of this block
// The host must follow the four-phase req/ack handshake with one access in flight
`timescale 1ns/1ps
`include "cartridge_settings.svh"

module sccMegaRom (
    input  logic                         CLK,
    input  logic                         RESET_n,
    input  logic                         i_req,
    input  cartridgePkg::busOp_t         i_op,
    input  logic [15:0]                  i_addr,
    input  logic [7:0]                   i_wrData,
    output logic                         o_ack,
    output logic [7:0]                   o_rdData,
    output logic                         o_romHit,
    output logic [`ROM_BANK_BITS+12:0]   o_romAddr
);

    mapBusIf mapBus ();
    sccBusIf sccBus ();

    // Sequencer and mode register
    cartridgeBusCtrl i_busCtrl (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .i_req     (i_req),
        .i_op      (i_op),
        .i_addr    (i_addr),
        .i_wrData  (i_wrData),
        .o_ack     (o_ack),
        .o_rdData  (o_rdData),
        .o_romHit  (o_romHit),
        .o_romAddr (o_romAddr),
        .mapBus    (mapBus.ctrl),
        .sccBus    (sccBus.ctrl)
    );

    // Page translation and sound window decode
    bankMapper i_bankMapper (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .bus     (mapBus.mapper)
    );

    // Waves and channel control
    sccSoundRegs i_sccSoundRegs (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .bus     (sccBus.regs)
    );

endmodule

/* logic/cartridgeBusCtrl.sv */
// Four-phase req/ack sequencer for one slot access at a time
// Ack rises ACK_LATENCY edges after req is first seen and falls once req drops
// A write to BFFEh/BFFFh goes to the mode register and reaches no other block
// o_romAddr reads 0 whenever o_romHit is low
`timescale 1ns/1ps
`include "cartridge_settings.svh"

module cartridgeBusCtrl (
    input  logic                         CLK,
    input  logic                         RESET_n,
    input  logic                         i_req,
    input  cartridgePkg::busOp_t         i_op,
    input  logic [15:0]                  i_addr,
    input  logic [7:0]                   i_wrData,
    output logic                         o_ack,
    output logic [7:0]                   o_rdData,
    output logic                         o_romHit,
    output logic [`ROM_BANK_BITS+12:0]   o_romAddr,
    mapBusIf.ctrl                        mapBus,
    sccBusIf.ctrl                        sccBus
);

    cartridgePkg::ctrlState_t state;

    // Mode register fields
    logic                   scciModeQ;
    logic [`BANK_COUNT-1:0] bankEnableQ;

    // Request copy for the second half of the access
    logic       modeWriteQ;
    logic       writeQ;
    logic [7:0] offsetQ;
    logic [7:0] wrDataQ;

    logic isWrite;
    logic isModeWrite;

    always_comb begin
        isWrite     = i_op == cartridgePkg::OP_WRITE;
        isModeWrite = isWrite && (i_addr[15:1] == 15'h5FFF);
    end

    // The host holds its request stable so the mapper samples it directly at E0
    always_comb begin
        mapBus.strobe     = (state == cartridgePkg::ST_IDLE) && i_req && !isModeWrite;
        mapBus.write      = isWrite;
        mapBus.addr       = i_addr;
        mapBus.wrData     = i_wrData;
        mapBus.scciMode   = scciModeQ;
        mapBus.bankEnable = bankEnableQ;
    end

    // Sound strobe at E0+1 once the mapper has confirmed the window
    always_comb begin
        sccBus.strobe   = (state == cartridgePkg::ST_DECODE) && mapBus.sccHit && !modeWriteQ;
        sccBus.write    = writeQ;
        sccBus.offset   = offsetQ;
        sccBus.wrData   = wrDataQ;
        sccBus.scciMode = scciModeQ;
    end

    always_ff @(posedge CLK) begin
        if (state == cartridgePkg::ST_IDLE && i_req) begin
            writeQ  <= isWrite;
            offsetQ <= i_addr[7:0];
            wrDataQ <= i_wrData;
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            state       <= cartridgePkg::ST_IDLE;
            modeWriteQ  <= 1'b0;
            scciModeQ   <= 1'b0;
            bankEnableQ <= '1;
            o_ack       <= 1'b0;
            o_rdData    <= 8'hFF;
            o_romHit    <= 1'b0;
            o_romAddr   <= '0;
        end else begin
            case (state)
                cartridgePkg::ST_IDLE: begin
                    if (i_req) begin
                        modeWriteQ <= isModeWrite;
                        state      <= cartridgePkg::ST_DECODE;
                    end
                end
                cartridgePkg::ST_DECODE: begin
                    if (modeWriteQ) begin
                        // Bit 5 picks SCC-I and bit 4 locks every bank
                        scciModeQ      <= wrDataQ[5];
                        bankEnableQ[0] <= !wrDataQ[4];
                        // Bits 0 to 2 lock banks 1 to 3 one by one
                        for (int n = 1; n < `BANK_COUNT; n++) begin
                            bankEnableQ[n] <= !(wrDataQ[4] || wrDataQ[n-1]);
                        end
                    end
                    state <= cartridgePkg::ST_ACCESS;
                end
                cartridgePkg::ST_ACCESS: begin
                    if (!modeWriteQ && mapBus.sccHit) begin
                        o_rdData  <= sccBus.rdData;
                        o_romHit  <= 1'b0;
                        o_romAddr <= '0;
                    end else if (!modeWriteQ && mapBus.romHit) begin
                        // ROM data comes from outside so the bus itself reads high
                        o_rdData  <= 8'hFF;
                        o_romHit  <= 1'b1;
                        o_romAddr <= mapBus.romAddr;
                    end else begin
                        o_rdData  <= 8'hFF;
                        o_romHit  <= 1'b0;
                        o_romAddr <= '0;
                    end
                    o_ack <= 1'b1;
                    state <= cartridgePkg::ST_ACK;
                end
                cartridgePkg::ST_ACK: begin
                    // Results stay put for as long as the host keeps req high
                    if (!i_req) begin
                        o_ack <= 1'b0;
                        state <= cartridgePkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= cartridgePkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* logic/sccSoundRegs.sv */
// Wave memory and channel control registers of the sound chip
// The offset is the low address byte inside the decoded sound window
// Control registers are write-only in both modes and read back as FFh
// In SCC mode a write to channel 3's wave also updates channel 4
`timescale 1ns/1ps
`include "cartridge_settings.svh"

module sccSoundRegs (
    input  logic  CLK,
    input  logic  RESET_n,
    sccBusIf.regs bus
);

    localparam int WaveBytes = 160;
    localparam int CtrlBytes = 16;

    // Five channels of 32 signed samples each
    logic [7:0] waveMem [WaveBytes];

    // Ten frequency bytes, five volumes and the channel enable byte
    logic [7:0] ctrlReg [CtrlBytes];

    logic waveHit;
    logic ctrlHit;
    logic mirrorCh4;

    // Drops the bits that have no storage on the real chip
    function automatic logic [7:0] maskCtrl(input logic [3:0] idx, input logic [7:0] data);
        logic [7:0] masked;
        masked = data;
        if (idx < 4'd10) begin
            // Odd frequency bytes only carry the upper 4 bits of the 12-bit period
            if (idx[0]) begin
                masked = {4'h0, data[3:0]};
            end
        end else if (idx < 4'd15) begin
            // Volumes are 4 bits
            masked = {4'h0, data[3:0]};
        end else begin
            // One enable bit per channel
            masked = {3'b000, data[4:0]};
        end
        return masked;
    endfunction

    // Decode the offset against the current layout
    always_comb begin
        if (bus.scciMode) begin
            // SCC-I gives every channel its own wave at 00h-9Fh
            waveHit   = bus.offset < 8'(WaveBytes);
            ctrlHit   = bus.offset[7:5] == 3'b101;
            mirrorCh4 = 1'b0;
        end else begin
            // SCC only decodes four waves at 00h-7Fh
            waveHit   = !bus.offset[7];
            ctrlHit   = bus.offset[7:5] == 3'b100;
            mirrorCh4 = bus.offset[7:5] == 3'b011;
        end
    end

    // Wave memory
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < WaveBytes; i++) begin
                waveMem[i] <= 8'h00;
            end
        end else if (bus.strobe && bus.write && waveHit) begin
            waveMem[bus.offset] <= bus.wrData;
            // Keep channel 4 in step so a later switch to SCC-I sees the same wave
            if (mirrorCh4) begin
                waveMem[{3'b100, bus.offset[4:0]}] <= bus.wrData;
            end
        end
    end

    // Control bytes are mirrored every 16 offsets in both modes
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < CtrlBytes; i++) begin
                ctrlReg[i] <= 8'h00;
            end
        end else if (bus.strobe && bus.write && ctrlHit) begin
            ctrlReg[bus.offset[3:0]] <= maskCtrl(bus.offset[3:0], bus.wrData);
        end
    end

    // Read data is ready one cycle after the strobe
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            bus.rdData <= 8'hFF;
        end else if (bus.strobe) begin
            if (!bus.write && waveHit) begin
                bus.rdData <= waveMem[bus.offset];
            end else begin
                // Writes and undecoded offsets float the data bus
                bus.rdData <= 8'hFF;
            end
        end
    end

endmodule

/* logic/bankMapper.sv */
// Bank registers and ROM page translation for 4000h to BFFFh
// Results are registered on the strobe and hold until the next strobe
// Bank register writes are gated by bankEnable from the mode register
// A sound window hit always clears the ROM hit for the same access
`timescale 1ns/1ps
`include "cartridge_settings.svh"

module bankMapper (
    input  logic     CLK,
    input  logic     RESET_n,
    mapBusIf.mapper  bus
);

    localparam int RomAddrBits = `ROM_BANK_BITS + 13;

    // Raw 8-bit bank values since the sound window decode looks at bits above the ROM width
    logic [7:0] bankReg [`BANK_COUNT];

    logic                   inRomWindow;
    logic [1:0]             bankIdx;
    logic                   isBankWrite;
    logic                   sccWindow;
    logic [RomAddrBits-1:0] romAddrNext;

    always_comb begin
        // Only 4000h-7FFFh and 8000h-BFFFh belong to the cartridge ROM
        inRomWindow = bus.addr[15] ^ bus.addr[14];

        // Page 4000h maps to bank 0 and A000h to bank 3
        // Within the window this is bits 14:13 offset by two pages
        bankIdx = {bus.addr[15], bus.addr[13]};

        // Bank register windows are 5000h, 7000h, 9000h and B000h, each 2 KB
        isBankWrite = bus.write && inRomWindow && (bus.addr[12:11] == 2'b10);

        // The sound window moves with the mode and is opened by a bank value
        if (bus.scciMode) begin
            // SCC-I uses B800h-BFFFh once bank 3 has bit 7 set
            sccWindow = (bus.addr[15:11] == 5'b10111) && bankReg[3][7];
        end else begin
            // Plain SCC uses 9800h-9FFFh once bank 2 holds 3Fh in its low bits
            sccWindow = (bus.addr[15:11] == 5'b10011) && (bankReg[2][5:0] == 6'h3F);
        end

        // Page number on top of the offset inside the 8 KB page
        romAddrNext = {bankReg[bankIdx][`ROM_BANK_BITS-1:0], bus.addr[12:0]};
    end

    // Bank registers start as a linear map of the first four pages
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < `BANK_COUNT; i++) begin
                bankReg[i] <= 8'(i);
            end
        end else if (bus.strobe && isBankWrite && bus.bankEnable[bankIdx]) begin
            bankReg[bankIdx] <= bus.wrData;
        end
    end

    // Result registers, read by the controller one cycle after the strobe
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            bus.romHit  <= 1'b0;
            bus.romAddr <= '0;
            bus.sccHit  <= 1'b0;
        end else if (bus.strobe) begin
            bus.sccHit <= sccWindow;
            // The sound window sits inside the ROM window and wins over it
            bus.romHit <= inRomWindow && !sccWindow;
            // Translation uses the bank value from before any write in this access
            if (inRomWindow && !sccWindow) begin
                bus.romAddr <= romAddrNext;
            end else begin
                bus.romAddr <= '0;
            end
        end
    end

endmodule

/* logic/cartridgeIfs.sv */
// Internal buses between the controller and its two helper blocks
// Strobes are single-cycle and all results coming back are registered
`timescale 1ns/1ps
`include "cartridge_settings.svh"

// Controller to bank mapper
interface mapBusIf;
    logic                         strobe;
    logic                         write;
    logic [15:0]                  addr;
    logic [7:0]                   wrData;
    logic                         scciMode;
    logic [`BANK_COUNT-1:0]       bankEnable;
    logic                         romHit;
    logic [`ROM_BANK_BITS+12:0]   romAddr;
    logic                         sccHit;

    modport ctrl (output strobe, write, addr, wrData, scciMode, bankEnable,
                  input romHit, romAddr, sccHit);
    modport mapper (input strobe, write, addr, wrData, scciMode, bankEnable,
                    output romHit, romAddr, sccHit);
endinterface

// Controller to sound register file
interface sccBusIf;
    logic       strobe;
    logic       write;
    logic [7:0] offset;
    logic [7:0] wrData;
    logic       scciMode;
    logic [7:0] rdData;

    modport ctrl (output strobe, write, offset, wrData, scciMode, input rdData);
    modport regs (input strobe, write, offset, wrData, scciMode, output rdData);
endinterface

/* logic/cartridgePkg.sv */
// Shared types for the MegaROM cartridge front end
// Only the opcode and controller state encodings live here
`include "cartridge_settings.svh"

package cartridgePkg;

    // Direction of one slot access from the host
    typedef enum logic [0:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } busOp_t;

    // Request sequence inside the bus controller
    // IDLE waits for req and strobes the mapper
    // DECODE sees the mapper result and strobes the sound registers
    // ACCESS collects the read result and raises ack
    // ACK holds the result until req falls
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_DECODE = 2'd1,
        ST_ACCESS = 2'd2,
        ST_ACK    = 2'd3
    } ctrlState_t;

endpackage

/* logic/cartridge_settings.svh */
// Build-time sizes for the MegaROM cartridge front end
// The ROM address is ROM_BANK_BITS plus the 13 bits of an 8 KB page
// BANK_COUNT must stay 4 since the bank index comes from two address bits
`ifndef CARTRIDGE_SETTINGS_SVH
`define CARTRIDGE_SETTINGS_SVH

// Four 8 KB pages cover 4000h to BFFFh
`define BANK_COUNT 4

// Six bank bits address a 512 KB ROM
`define ROM_BANK_BITS 6

// Rising edges from the first edge that sees req high up to the edge that raises ack
`define ACK_LATENCY 3

`endif
